// ==== src/sys_bus_pkg.sv ====
// --------------------------------------------------
// Widths, AXI response codes and the address map
// of the peripheral block. Data is fixed at 32 bits
// because only single 4-byte transfers are legal.
// --------------------------------------------------
`default_nettype none

package sys_bus_pkg;

  typedef logic [31:0] sys_addr_t;  // Byte address, AXI and system bus
  typedef logic [31:0] sys_data_t;  // Data word
  typedef logic [3:0]  sys_sel_t;   // One select bit per data byte
  typedef logic [1:0]  axi_resp_t;  // AXI BRESP / RRESP code

  // --------------------------------------------------
  // Response codes
  // --------------------------------------------------
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // --------------------------------------------------
  // Address map, 1 MB regions
  // --------------------------------------------------
  localparam sys_addr_t REG_BASE    = 32'h4000_0000;  // Register bank
  localparam sys_addr_t RAM_BASE    = 32'h4010_0000;  // Wait-state RAM
  localparam sys_addr_t REGION_MASK = 32'hFFF0_0000;  // Region select bits

  localparam sys_data_t REG_ID_VALUE = 32'h5AB1_0100;  // Read-only ID word

endpackage : sys_bus_pkg

`default_nettype wire

// ==== src/axi_slave.sv ====
// --------------------------------------------------
// AXI3 slave for single 32-bit beats only. Bursts and
// sizes other than 4 bytes get SLVERR. One command at
// a time, write wins. Lock, cache, prot, burst and
// wid are accepted and ignored.
// --------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module axi_slave
  import sys_bus_pkg::*;
#(
  parameter int unsigned AXI_IW      = 8,   // ID width
  parameter int unsigned ACK_TIMEOUT = 32   // Cycles to wait for sys ack
) (
  input  wire logic              axi_clk_i,
  input  wire logic              axi_rstn_i,
  // Write address channel
  input  wire logic [AXI_IW-1:0] axi_awid_i,
  input  wire sys_addr_t         axi_awaddr_i,
  input  wire logic [3:0]        axi_awlen_i,
  input  wire logic [2:0]        axi_awsize_i,
  input  wire logic [1:0]        axi_awburst_i,
  input  wire logic [1:0]        axi_awlock_i,
  input  wire logic [3:0]        axi_awcache_i,
  input  wire logic [2:0]        axi_awprot_i,
  input  wire logic              axi_awvalid_i,
  output logic                   axi_awready_o,
  // Write data channel
  input  wire logic [AXI_IW-1:0] axi_wid_i,
  input  wire sys_data_t         axi_wdata_i,
  input  wire sys_sel_t          axi_wstrb_i,
  input  wire logic              axi_wlast_i,
  input  wire logic              axi_wvalid_i,
  output logic                   axi_wready_o,
  // Write response channel
  output logic [AXI_IW-1:0]      axi_bid_o,
  output axi_resp_t              axi_bresp_o,
  output logic                   axi_bvalid_o,
  input  wire logic              axi_bready_i,
  // Read address channel
  input  wire logic [AXI_IW-1:0] axi_arid_i,
  input  wire sys_addr_t         axi_araddr_i,
  input  wire logic [3:0]        axi_arlen_i,
  input  wire logic [2:0]        axi_arsize_i,
  input  wire logic [1:0]        axi_arburst_i,
  input  wire logic [1:0]        axi_arlock_i,
  input  wire logic [3:0]        axi_arcache_i,
  input  wire logic [2:0]        axi_arprot_i,
  input  wire logic              axi_arvalid_i,
  output logic                   axi_arready_o,
  // Read data channel
  output logic [AXI_IW-1:0]      axi_rid_o,
  output sys_data_t              axi_rdata_o,
  output axi_resp_t              axi_rresp_o,
  output logic                   axi_rlast_o,
  output logic                   axi_rvalid_o,
  input  wire logic              axi_rready_i,
  // System bus
  output sys_addr_t              sys_addr_o,
  output sys_data_t              sys_wdata_o,
  output sys_sel_t               sys_sel_o,
  output logic                   sys_wen_o,
  output logic                   sys_ren_o,
  input  wire sys_data_t         sys_rdata_i,
  input  wire logic              sys_err_i,
  input  wire logic              sys_ack_i
);

  localparam int CW = $clog2(ACK_TIMEOUT + 1);  // Timeout counter width

  typedef enum logic [2:0] {
    IDLE, WR_DATA, WR_WAIT, RD_WAIT, WR_RESP, RD_RESP
  } state_t;

  state_t            state;
  logic [AXI_IW-1:0] id_q;      // ID of the transfer in flight
  logic              req_err;   // Malformed request latched
  axi_resp_t         resp_q;
  sys_data_t         rdata_q;
  logic [CW-1:0]     tmo_cnt;   // Cycles since address acceptance

  logic aw_hs, w_hs, ar_hs;
  logic aw_bad, ar_bad;
  logic wait_st, timeout;

  // --------------------------------------------------
  // Handshakes and request checks
  // --------------------------------------------------
  assign axi_awready_o = (state == IDLE);
  assign axi_arready_o = (state == IDLE) && !axi_awvalid_i;  // Write has priority
  assign axi_wready_o  = (state == WR_DATA);                  // Only after AW taken

  assign aw_hs = axi_awvalid_i && axi_awready_o;
  assign ar_hs = axi_arvalid_i && axi_arready_o;
  assign w_hs  = axi_wvalid_i && axi_wready_o;

  assign aw_bad = (axi_awlen_i != 4'd0) || (axi_awsize_i != 3'd2);  // Burst or not 4 B
  assign ar_bad = (axi_arlen_i != 4'd0) || (axi_arsize_i != 3'd2);

  assign wait_st = (state == WR_WAIT) || (state == RD_WAIT);
  assign timeout = (tmo_cnt == CW'(ACK_TIMEOUT));

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------
  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      state     <= IDLE;
      tmo_cnt   <= '0;
      sys_wen_o <= 1'b0;
      sys_ren_o <= 1'b0;
    end else begin
      sys_wen_o <= w_hs && !req_err;   // One pulse per good write
      sys_ren_o <= ar_hs && !ar_bad;   // One pulse per good read

      if (aw_hs || ar_hs) begin
        tmo_cnt <= CW'(1);             // Count from acceptance
      end else if (state != IDLE && !timeout) begin
        tmo_cnt <= tmo_cnt + CW'(1);   // Saturates at ACK_TIMEOUT
      end

      case (state)
        IDLE: begin
          if (aw_hs) begin
            state <= WR_DATA;
          end else if (ar_hs) begin
            state <= ar_bad ? RD_RESP : RD_WAIT;  // Bad read answered at once
          end
        end
        WR_DATA: begin
          if (w_hs) begin
            state <= req_err ? WR_RESP : WR_WAIT;
          end
        end
        WR_WAIT: if (sys_ack_i || timeout) state <= WR_RESP;
        RD_WAIT: if (sys_ack_i || timeout) state <= RD_RESP;
        WR_RESP: if (axi_bready_i) state <= IDLE;  // Held until taken
        RD_RESP: if (axi_rready_i) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Request and response payload
  // --------------------------------------------------
  always_ff @(posedge axi_clk_i) begin
    if (aw_hs) begin
      id_q       <= axi_awid_i;
      sys_addr_o <= axi_awaddr_i;
      req_err    <= aw_bad;
      resp_q     <= aw_bad ? RESP_SLVERR : RESP_OKAY;
      rdata_q    <= '0;
    end else if (ar_hs) begin
      id_q       <= axi_arid_i;
      sys_addr_o <= axi_araddr_i;
      req_err    <= ar_bad;
      resp_q     <= ar_bad ? RESP_SLVERR : RESP_OKAY;
      rdata_q    <= '0;
    end

    if (w_hs) begin
      sys_wdata_o <= axi_wdata_i;
      sys_sel_o   <= axi_wstrb_i;  // Byte select from wstrb
    end

    if (wait_st && sys_ack_i) begin
      resp_q  <= sys_err_i ? RESP_SLVERR : RESP_OKAY;
      rdata_q <= sys_rdata_i;
    end else if (wait_st && timeout) begin
      resp_q  <= RESP_SLVERR;      // No slave answered
    end
  end

  // Both response channels share the latched payload
  assign axi_bid_o    = id_q;
  assign axi_bresp_o  = resp_q;
  assign axi_bvalid_o = (state == WR_RESP);

  assign axi_rid_o    = id_q;
  assign axi_rdata_o  = rdata_q;
  assign axi_rresp_o  = resp_q;
  assign axi_rvalid_o = (state == RD_RESP);
  assign axi_rlast_o  = axi_rvalid_o;  // Single beat

endmodule : axi_slave

`default_nettype wire

// ==== src/sys_bus_decoder.sv ====
// --------------------------------------------------
// Combinational region decoder. Unmatched addresses
// get no ack, which leaves them to the slave timeout.
// --------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module sys_bus_decoder
  import sys_bus_pkg::*;
(
  input  wire sys_addr_t sys_addr_i,
  input  wire logic      sys_wen_i,
  input  wire logic      sys_ren_i,
  output logic           reg_wen_o,
  output logic           reg_ren_o,
  output logic           ram_wen_o,
  output logic           ram_ren_o,
  input  wire sys_data_t reg_rdata_i,
  input  wire logic      reg_ack_i,
  input  wire logic      reg_err_i,
  input  wire sys_data_t ram_rdata_i,
  input  wire logic      ram_ack_i,
  input  wire logic      ram_err_i,
  output sys_data_t      sys_rdata_o,
  output logic           sys_ack_o,
  output logic           sys_err_o
);

  logic reg_hit, ram_hit;

  assign reg_hit = ((sys_addr_i & REGION_MASK) == REG_BASE);
  assign ram_hit = ((sys_addr_i & REGION_MASK) == RAM_BASE);

  // Enables go only to the matched region
  assign reg_wen_o = sys_wen_i && reg_hit;
  assign reg_ren_o = sys_ren_i && reg_hit;
  assign ram_wen_o = sys_wen_i && ram_hit;
  assign ram_ren_o = sys_ren_i && ram_hit;

  // Address is held by the slave, so the reply mux stays stable
  always_comb begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    sys_err_o   = 1'b0;
    if (reg_hit) begin
      sys_rdata_o = reg_rdata_i;
      sys_ack_o   = reg_ack_i;
      sys_err_o   = reg_err_i;
    end else if (ram_hit) begin
      sys_rdata_o = ram_rdata_i;
      sys_ack_o   = ram_ack_i;
      sys_err_o   = ram_err_i;
    end
  end

endmodule : sys_bus_decoder

`default_nettype wire

// ==== src/reg_bank.sv ====
// --------------------------------------------------
// Word 0 is the read-only ID, words 1 to 3 scratch.
// Ack one cycle after wen or ren. Writes to word 0
// and any access above word 3 return err.
// --------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module reg_bank
  import sys_bus_pkg::*;
(
  input  wire logic      axi_clk_i,
  input  wire logic      axi_rstn_i,
  input  wire sys_addr_t addr_i,
  input  wire sys_data_t wdata_i,
  input  wire sys_sel_t  sel_i,
  input  wire logic      wen_i,
  input  wire logic      ren_i,
  output sys_data_t      rdata_o,
  output logic           ack_o,
  output logic           err_o
);

  sys_data_t scratch [1:3];   // Scratch registers
  sys_addr_t offset;          // Byte offset inside the region
  logic [1:0] idx;            // Word index
  logic      out_range;

  assign offset    = addr_i & ~REGION_MASK;
  assign idx       = offset[3:2];
  assign out_range = |offset[31:4];  // Beyond word 3

  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      scratch <= '{default: '0};
    end else begin
      ack_o <= wen_i || ren_i;
      if (wen_i) begin
        err_o <= out_range || (idx == 2'd0);  // ID is read-only
        if (!out_range && idx != 2'd0) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) scratch[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else if (ren_i) begin
        err_o <= out_range;
      end
    end
  end

  // Read data, valid together with ack
  always_ff @(posedge axi_clk_i) begin
    if (ren_i) begin
      if (out_range)          rdata_o <= '0;
      else if (idx == 2'd0)   rdata_o <= REG_ID_VALUE;
      else                    rdata_o <= scratch[idx];
    end
  end

endmodule : reg_bank

`default_nettype wire

// ==== src/wait_state_ram.sv ====
// --------------------------------------------------
// Word RAM of 2^RAM_AW words, byte-wise writes.
// Ack RAM_WAIT+1 cycles after wen or ren. Address
// wraps inside the RAM; err is never raised.
// --------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module wait_state_ram
  import sys_bus_pkg::*;
#(
  parameter int unsigned RAM_WAIT = 3,  // Wait states before ack
  parameter int unsigned RAM_AW   = 6   // Word address width
) (
  input  wire logic      axi_clk_i,
  input  wire logic      axi_rstn_i,
  input  wire sys_addr_t addr_i,
  input  wire sys_data_t wdata_i,
  input  wire sys_sel_t  sel_i,
  input  wire logic      wen_i,
  input  wire logic      ren_i,
  output sys_data_t      rdata_o,
  output logic           ack_o,
  output logic           err_o
);

  localparam int CW = $clog2(RAM_WAIT + 2);  // Holds RAM_WAIT+1

  sys_data_t         mem [2**RAM_AW];
  logic [RAM_AW-1:0] waddr;     // Word address, upper bits dropped
  logic [CW-1:0]     wait_cnt;  // Cycles left until ack

  assign waddr = addr_i[RAM_AW+1:2];

  // --------------------------------------------------
  // Storage, accessed in the command cycle
  // --------------------------------------------------
  always_ff @(posedge axi_clk_i) begin
    if (wen_i) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) mem[waddr][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
    if (ren_i) rdata_o <= mem[waddr];
  end

  // --------------------------------------------------
  // Wait-state counter
  // --------------------------------------------------
  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      wait_cnt <= '0;
    end else if (wen_i || ren_i) begin
      wait_cnt <= CW'(RAM_WAIT + 1);  // Load on command
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - CW'(1);
    end
  end

  assign ack_o = (wait_cnt == CW'(1));  // Last count, one-cycle pulse
  assign err_o = 1'b0;

endmodule : wait_state_ram

`default_nettype wire

// ==== src/axi_sys_top.sv ====
// --------------------------------------------------
// Peripheral block top: AXI3 slave, region decoder,
// register bank and wait-state RAM. All parameters
// are set here.
// --------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module axi_sys_top
  import sys_bus_pkg::*;
#(
  parameter int unsigned AXI_IW      = 8,
  parameter int unsigned ACK_TIMEOUT = 32,
  parameter int unsigned RAM_WAIT    = 3,
  parameter int unsigned RAM_AW      = 6
) (
  input  wire logic              axi_clk_i,
  input  wire logic              axi_rstn_i,
  input  wire logic [AXI_IW-1:0] axi_awid_i,
  input  wire sys_addr_t         axi_awaddr_i,
  input  wire logic [3:0]        axi_awlen_i,
  input  wire logic [2:0]        axi_awsize_i,
  input  wire logic [1:0]        axi_awburst_i,
  input  wire logic [1:0]        axi_awlock_i,
  input  wire logic [3:0]        axi_awcache_i,
  input  wire logic [2:0]        axi_awprot_i,
  input  wire logic              axi_awvalid_i,
  output logic                   axi_awready_o,
  input  wire logic [AXI_IW-1:0] axi_wid_i,
  input  wire sys_data_t         axi_wdata_i,
  input  wire sys_sel_t          axi_wstrb_i,
  input  wire logic              axi_wlast_i,
  input  wire logic              axi_wvalid_i,
  output logic                   axi_wready_o,
  output logic [AXI_IW-1:0]      axi_bid_o,
  output axi_resp_t              axi_bresp_o,
  output logic                   axi_bvalid_o,
  input  wire logic              axi_bready_i,
  input  wire logic [AXI_IW-1:0] axi_arid_i,
  input  wire sys_addr_t         axi_araddr_i,
  input  wire logic [3:0]        axi_arlen_i,
  input  wire logic [2:0]        axi_arsize_i,
  input  wire logic [1:0]        axi_arburst_i,
  input  wire logic [1:0]        axi_arlock_i,
  input  wire logic [3:0]        axi_arcache_i,
  input  wire logic [2:0]        axi_arprot_i,
  input  wire logic              axi_arvalid_i,
  output logic                   axi_arready_o,
  output logic [AXI_IW-1:0]      axi_rid_o,
  output sys_data_t              axi_rdata_o,
  output axi_resp_t              axi_rresp_o,
  output logic                   axi_rlast_o,
  output logic                   axi_rvalid_o,
  input  wire logic              axi_rready_i
);

  // --------------------------------------------------
  // System bus nets
  // --------------------------------------------------
  sys_addr_t sys_addr;
  sys_data_t sys_wdata, sys_rdata;
  sys_sel_t  sys_sel;
  logic      sys_wen, sys_ren, sys_ack, sys_err;

  sys_data_t reg_rdata, ram_rdata;
  logic      reg_wen, reg_ren, reg_ack, reg_err;
  logic      ram_wen, ram_ren, ram_ack, ram_err;

  axi_slave #(
    .AXI_IW      (AXI_IW),
    .ACK_TIMEOUT (ACK_TIMEOUT)
  ) i_axi_slave (
    .axi_clk_i, .axi_rstn_i,
    .axi_awid_i, .axi_awaddr_i, .axi_awlen_i, .axi_awsize_i, .axi_awburst_i,
    .axi_awlock_i, .axi_awcache_i, .axi_awprot_i, .axi_awvalid_i, .axi_awready_o,
    .axi_wid_i, .axi_wdata_i, .axi_wstrb_i, .axi_wlast_i, .axi_wvalid_i, .axi_wready_o,
    .axi_bid_o, .axi_bresp_o, .axi_bvalid_o, .axi_bready_i,
    .axi_arid_i, .axi_araddr_i, .axi_arlen_i, .axi_arsize_i, .axi_arburst_i,
    .axi_arlock_i, .axi_arcache_i, .axi_arprot_i, .axi_arvalid_i, .axi_arready_o,
    .axi_rid_o, .axi_rdata_o, .axi_rresp_o, .axi_rlast_o, .axi_rvalid_o, .axi_rready_i,
    .sys_addr_o  (sys_addr),
    .sys_wdata_o (sys_wdata),
    .sys_sel_o   (sys_sel),
    .sys_wen_o   (sys_wen),
    .sys_ren_o   (sys_ren),
    .sys_rdata_i (sys_rdata),
    .sys_err_i   (sys_err),
    .sys_ack_i   (sys_ack)
  );

  sys_bus_decoder i_sys_bus_decoder (
    .sys_addr_i  (sys_addr),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .reg_wen_o   (reg_wen),
    .reg_ren_o   (reg_ren),
    .ram_wen_o   (ram_wen),
    .ram_ren_o   (ram_ren),
    .reg_rdata_i (reg_rdata),
    .reg_ack_i   (reg_ack),
    .reg_err_i   (reg_err),
    .ram_rdata_i (ram_rdata),
    .ram_ack_i   (ram_ack),
    .ram_err_i   (ram_err),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err)
  );

  reg_bank i_reg_bank (
    .axi_clk_i, .axi_rstn_i,
    .addr_i  (sys_addr),
    .wdata_i (sys_wdata),
    .sel_i   (sys_sel),
    .wen_i   (reg_wen),
    .ren_i   (reg_ren),
    .rdata_o (reg_rdata),
    .ack_o   (reg_ack),
    .err_o   (reg_err)
  );

  wait_state_ram #(
    .RAM_WAIT (RAM_WAIT),
    .RAM_AW   (RAM_AW)
  ) i_wait_state_ram (
    .axi_clk_i, .axi_rstn_i,
    .addr_i  (sys_addr),
    .wdata_i (sys_wdata),
    .sel_i   (sys_sel),
    .wen_i   (ram_wen),
    .ren_i   (ram_ren),
    .rdata_o (ram_rdata),
    .ack_o   (ram_ack),
    .err_o   (ram_err)
  );

endmodule : axi_sys_top

`default_nettype wire

// ==== tests/axi_master_tasks.svh ====
// --------------------------------------------------
// AXI3 master tasks for single 4-byte beats only.
// Included inside tb_axi_sys_top; uses its signals,
// stop_run, check_eq and WAIT_LIMIT. Inputs change
// on the falling edge and outputs are sampled there.
// --------------------------------------------------
`ifndef AXI_MASTER_TASKS_SVH
`define AXI_MASTER_TASKS_SVH

// One falling edge of a bounded wait
task automatic step_wait(input string what, inout int n);
  @(negedge axi_clk);
  n++;
  if (n > WAIT_LIMIT) stop_run({"Timeout while waiting for ", what});
endtask

// No new address may be taken while a transfer is open
task automatic check_blocked();
  check_eq("axi_awready", 32'(axi_awready), 32'd0);
  check_eq("axi_arready", 32'(axi_arready), 32'd0);
endtask

// --------------------------------------------------
// Single write with a random bready delay
// --------------------------------------------------
task automatic axi_write(input logic [AXI_IW-1:0] id, input sys_addr_t addr,
                         input sys_data_t data, input sys_sel_t strb, input logic [3:0] len,
                         output axi_resp_t resp, output logic [AXI_IW-1:0] bid);
  int n;
  int hold;
  axi_awid    = id;
  axi_awaddr  = addr;
  axi_awlen   = len;
  axi_awsize  = 3'd2;
  axi_awvalid = 1'b1;
  axi_wid     = id;
  axi_wdata   = data;
  axi_wstrb   = strb;
  axi_wlast   = 1'b1;
  axi_wvalid  = 1'b1;            // W offered together with AW
  n = 0;
  while (!axi_awready) step_wait("awready", n);
  @(negedge axi_clk);            // AW taken on the rising edge
  axi_awvalid = 1'b0;
  accept_cyc  = cycle_cnt;
  n = 0;
  while (!axi_wready) step_wait("wready", n);
  @(negedge axi_clk);
  axi_wvalid = 1'b0;
  n = 0;
  while (!axi_bvalid) begin
    check_blocked();
    step_wait("bvalid", n);
  end
  resp_cyc = cycle_cnt;
  resp     = axi_bresp;
  bid      = axi_bid;
  hold     = int'($urandom % 5);  // Back-pressure cycles
  repeat (hold) begin
    @(negedge axi_clk);
    check_blocked();
    check_eq("axi_bvalid", 32'(axi_bvalid), 32'd1);
    check_eq("axi_bresp", 32'(axi_bresp), 32'(resp));
    check_eq("axi_bid", 32'(axi_bid), 32'(bid));
  end
  axi_bready = 1'b1;
  @(negedge axi_clk);
  axi_bready = 1'b0;
endtask

// Drives the AR channel only and serves the priority case too
task automatic raise_ar(input logic [AXI_IW-1:0] id, input sys_addr_t addr,
                        input logic [2:0] size);
  axi_arid    = id;
  axi_araddr  = addr;
  axi_arlen   = 4'd0;
  axi_arsize  = size;
  axi_arvalid = 1'b1;
endtask

// --------------------------------------------------
// Single read with a random rready delay
// --------------------------------------------------
task automatic axi_read(input logic [AXI_IW-1:0] id, input sys_addr_t addr,
                        input logic [2:0] size, output sys_data_t data,
                        output axi_resp_t resp, output logic [AXI_IW-1:0] rid);
  int n;
  int hold;
  raise_ar(id, addr, size);
  n = 0;
  while (!axi_arready) step_wait("arready", n);
  @(negedge axi_clk);
  axi_arvalid = 1'b0;
  accept_cyc  = cycle_cnt;
  n = 0;
  while (!axi_rvalid) begin
    check_blocked();
    check_eq("axi_rlast", 32'(axi_rlast), 32'd0);  // No beat yet
    step_wait("rvalid", n);
  end
  resp_cyc = cycle_cnt;
  data     = axi_rdata;
  resp     = axi_rresp;
  rid      = axi_rid;
  hold     = int'($urandom % 5);
  repeat (hold) begin
    @(negedge axi_clk);
    check_blocked();
    check_eq("axi_rvalid", 32'(axi_rvalid), 32'd1);
    check_eq("axi_rlast", 32'(axi_rlast), 32'd1);
    check_eq("axi_rdata", axi_rdata, data);  // Held stable under back-pressure
    check_eq("axi_rresp", 32'(axi_rresp), 32'(resp));
    check_eq("axi_rid", 32'(axi_rid), 32'(rid));
  end
  axi_rready = 1'b1;
  @(negedge axi_clk);
  axi_rready = 1'b0;
endtask

`endif

// ==== tests/tb_axi_sys_top.sv ====
// --------------------------------------------------
// Testbench for axi_sys_top. Stops at the first
// mismatch. RAM words are only read after a full
// write, since the RAM has no reset.
// --------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module tb_axi_sys_top
  import sys_bus_pkg::*;
();

  localparam int unsigned AXI_IW      = 8;
  localparam int unsigned ACK_TIMEOUT = 32;
  localparam int unsigned RAM_WAIT    = 3;
  localparam int unsigned RAM_AW      = 6;
  localparam int          WAIT_LIMIT  = 100;  // Beyond ACK_TIMEOUT

  logic axi_clk, axi_rstn;
  logic [AXI_IW-1:0] axi_awid, axi_wid, axi_arid, axi_bid, axi_rid;
  sys_addr_t axi_awaddr, axi_araddr;
  logic [3:0] axi_awlen, axi_arlen, axi_awcache, axi_arcache;
  logic [2:0] axi_awsize, axi_arsize, axi_awprot, axi_arprot;
  logic [1:0] axi_awburst, axi_arburst, axi_awlock, axi_arlock;
  logic axi_awvalid, axi_awready, axi_wlast, axi_wvalid, axi_wready;
  logic axi_bvalid, axi_bready, axi_arvalid, axi_arready;
  logic axi_rlast, axi_rvalid, axi_rready;
  sys_data_t axi_wdata, axi_rdata;
  sys_sel_t  axi_wstrb;
  axi_resp_t axi_bresp, axi_rresp;

  int cycle_cnt;                       // Rising edges since reset
  int accept_cyc, resp_cyc;            // Set by the master tasks
  sys_data_t reg_model [1:3];          // Expected scratch contents
  sys_data_t ram_model [2**RAM_AW];
  logic [RAM_AW-1:0] ram_idx [$];      // Word indices written so far
  logic [RAM_AW-1:0] widx;
  logic [AXI_IW-1:0] id, bid, rid;
  sys_data_t rd_data, wr_data;
  sys_sel_t  wr_sel;
  axi_resp_t resp;
  int        ridx;

  // --------------------------------------------------
  // Failure reporting and checks
  // --------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp));
    end
  endtask

  // New bytes replace old ones where the select bit is set
  function automatic sys_data_t merge_bytes(input sys_data_t old_v, input sys_data_t new_v,
                                            input sys_sel_t sel);
    sys_data_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  function automatic sys_addr_t ram_addr(input logic [RAM_AW-1:0] w);
    return RAM_BASE | (sys_addr_t'(w) << 2);
  endfunction

  `include "axi_master_tasks.svh"

  axi_sys_top #(
    .AXI_IW(AXI_IW), .ACK_TIMEOUT(ACK_TIMEOUT), .RAM_WAIT(RAM_WAIT), .RAM_AW(RAM_AW)
  ) i_axi_sys_top (
    .axi_clk_i(axi_clk), .axi_rstn_i(axi_rstn),
    .axi_awid_i(axi_awid), .axi_awaddr_i(axi_awaddr), .axi_awlen_i(axi_awlen),
    .axi_awsize_i(axi_awsize), .axi_awburst_i(axi_awburst), .axi_awlock_i(axi_awlock),
    .axi_awcache_i(axi_awcache), .axi_awprot_i(axi_awprot),
    .axi_awvalid_i(axi_awvalid), .axi_awready_o(axi_awready),
    .axi_wid_i(axi_wid), .axi_wdata_i(axi_wdata), .axi_wstrb_i(axi_wstrb),
    .axi_wlast_i(axi_wlast), .axi_wvalid_i(axi_wvalid), .axi_wready_o(axi_wready),
    .axi_bid_o(axi_bid), .axi_bresp_o(axi_bresp),
    .axi_bvalid_o(axi_bvalid), .axi_bready_i(axi_bready),
    .axi_arid_i(axi_arid), .axi_araddr_i(axi_araddr), .axi_arlen_i(axi_arlen),
    .axi_arsize_i(axi_arsize), .axi_arburst_i(axi_arburst), .axi_arlock_i(axi_arlock),
    .axi_arcache_i(axi_arcache), .axi_arprot_i(axi_arprot),
    .axi_arvalid_i(axi_arvalid), .axi_arready_o(axi_arready),
    .axi_rid_o(axi_rid), .axi_rdata_o(axi_rdata), .axi_rresp_o(axi_rresp),
    .axi_rlast_o(axi_rlast), .axi_rvalid_o(axi_rvalid), .axi_rready_i(axi_rready)
  );

  initial begin
    axi_clk = 1'b0;
    forever #4 axi_clk = ~axi_clk;     // 8 ns period
  end

  always @(posedge axi_clk) begin
    if (!axi_rstn) cycle_cnt <= 0;
    else           cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    void'($urandom(4));
    axi_rstn    = 1'b0;
    axi_awid    = '0;
    axi_awaddr  = '0;
    axi_awlen   = 4'd0;
    axi_awsize  = 3'd2;
    axi_awburst = 2'b01;               // INCR, ignored by the slave
    axi_awlock  = 2'b00;
    axi_awcache = 4'd0;
    axi_awprot  = 3'd0;
    axi_awvalid = 1'b0;
    axi_wid     = '0;
    axi_wdata   = '0;
    axi_wstrb   = 4'h0;
    axi_wlast   = 1'b0;
    axi_wvalid  = 1'b0;
    axi_bready  = 1'b0;
    axi_arid    = '0;
    axi_araddr  = '0;
    axi_arlen   = 4'd0;
    axi_arsize  = 3'd2;
    axi_arburst = 2'b01;
    axi_arlock  = 2'b00;
    axi_arcache = 4'd0;
    axi_arprot  = 3'd0;
    axi_arvalid = 1'b0;
    axi_rready  = 1'b0;
    reg_model   = '{default: '0};      // Scratch resets to zero
    repeat (5) @(negedge axi_clk);
    axi_rstn = 1'b1;
    @(negedge axi_clk);
    check_eq("axi_awready", 32'(axi_awready), 32'd1);
    check_eq("axi_arready", 32'(axi_arready), 32'd1);
    check_eq("axi_wready", 32'(axi_wready), 32'd0);
    check_eq("axi_bvalid", 32'(axi_bvalid), 32'd0);
    check_eq("axi_rvalid", 32'(axi_rvalid), 32'd0);

    // --------------------------------------------------
    // Register bank
    // --------------------------------------------------
    axi_read(8'h11, REG_BASE, 3'd2, rd_data, resp, rid);
    check_eq("axi_rdata", rd_data, REG_ID_VALUE);
    check_eq("axi_rresp", 32'(resp), 32'(RESP_OKAY));
    check_eq("axi_rid", 32'(rid), 32'h11);
    for (int r = 0; r < 9; r++) begin
      ridx    = 1 + r % 3;             // Each scratch word three times
      wr_data = $urandom;
      wr_sel  = 4'($urandom);
      axi_write(8'h12, REG_BASE + sys_addr_t'(4 * ridx), wr_data, wr_sel, 4'd0, resp, bid);
      check_eq("axi_bresp", 32'(resp), 32'(RESP_OKAY));
      reg_model[ridx] = merge_bytes(reg_model[ridx], wr_data, wr_sel);
      axi_read(8'h13, REG_BASE + sys_addr_t'(4 * ridx), 3'd2, rd_data, resp, rid);
      check_eq("axi_rdata", rd_data, reg_model[ridx]);
      check_eq("axi_rresp", 32'(resp), 32'(RESP_OKAY));
    end
    axi_write(8'h14, REG_BASE, $urandom, 4'hF, 4'd0, resp, bid);
    check_eq("axi_bresp", 32'(resp), 32'(RESP_SLVERR));  // ID word is read-only

    // --------------------------------------------------
    // Wait-state RAM
    // --------------------------------------------------
    for (int k = 0; k < 8; k++) begin
      widx    = RAM_AW'($urandom);
      wr_data = $urandom;
      id      = AXI_IW'($urandom);
      axi_write(id, ram_addr(widx), wr_data, 4'hF, 4'd0, resp, bid);
      check_eq("axi_bresp", 32'(resp), 32'(RESP_OKAY));
      check_eq("axi_bid", 32'(bid), 32'(id));
      ram_model[widx] = wr_data;
      ram_idx.push_back(widx);
    end
    widx    = ram_idx[2];
    wr_data = $urandom;
    wr_sel  = 4'($urandom);            // Partial write over a known word
    axi_write(8'h15, ram_addr(widx), wr_data, wr_sel, 4'd0, resp, bid);
    check_eq("axi_bresp", 32'(resp), 32'(RESP_OKAY));
    ram_model[widx] = merge_bytes(ram_model[widx], wr_data, wr_sel);
    foreach (ram_idx[k]) begin
      id = AXI_IW'($urandom);
      axi_read(id, ram_addr(ram_idx[k]), 3'd2, rd_data, resp, rid);
      check_eq("axi_rdata", rd_data, ram_model[ram_idx[k]]);
      check_eq("axi_rresp", 32'(resp), 32'(RESP_OKAY));
      check_eq("axi_rid", 32'(rid), 32'(id));
    end

    // --------------------------------------------------
    // Malformed requests leave the targets untouched
    // --------------------------------------------------
    widx = ram_idx[0];
    axi_write(8'h21, ram_addr(widx), ~ram_model[widx], 4'hF, 4'd1, resp, bid);
    check_eq("axi_bresp", 32'(resp), 32'(RESP_SLVERR));
    axi_read(8'h22, ram_addr(widx), 3'd1, rd_data, resp, rid);
    check_eq("axi_rresp", 32'(resp), 32'(RESP_SLVERR));
    axi_read(8'h23, ram_addr(widx), 3'd2, rd_data, resp, rid);
    check_eq("axi_rdata", rd_data, ram_model[widx]);
    axi_write(8'h24, REG_BASE + 32'd4, ~reg_model[1], 4'hF, 4'd3, resp, bid);
    check_eq("axi_bresp", 32'(resp), 32'(RESP_SLVERR));
    axi_read(8'h25, REG_BASE + 32'd4, 3'd2, rd_data, resp, rid);
    check_eq("axi_rdata", rd_data, reg_model[1]);

    // --------------------------------------------------
    // Unmapped address, answered by the timeout
    // --------------------------------------------------
    axi_write(8'h31, 32'h5000_0000, $urandom, 4'hF, 4'd0, resp, bid);
    check_eq("axi_bresp", 32'(resp), 32'(RESP_SLVERR));
    assert (resp_cyc - accept_cyc >= int'(ACK_TIMEOUT))
      else stop_run("Unmapped write was answered before the ack timeout");
    axi_read(8'h32, 32'h5000_0010, 3'd2, rd_data, resp, rid);
    check_eq("axi_rresp", 32'(resp), 32'(RESP_SLVERR));
    assert (resp_cyc - accept_cyc >= int'(ACK_TIMEOUT))
      else stop_run("Unmapped read was answered before the ack timeout");

    // --------------------------------------------------
    // AW and AR in the same cycle, write goes first
    // --------------------------------------------------
    widx    = ram_idx[1];
    wr_data = $urandom;
    raise_ar(8'h42, ram_addr(widx), 3'd2);
    axi_write(8'h41, ram_addr(widx), wr_data, 4'hF, 4'd0, resp, bid);
    check_eq("axi_bresp", 32'(resp), 32'(RESP_OKAY));
    check_eq("axi_bid", 32'(bid), 32'h41);
    axi_read(8'h42, ram_addr(widx), 3'd2, rd_data, resp, rid);
    check_eq("axi_rdata", rd_data, wr_data);
    check_eq("axi_rid", 32'(rid), 32'h42);

    $display("Testbench passed");
    $finish;
  end

endmodule : tb_axi_sys_top

`default_nettype wire

// ==== sim.f ====
src/sys_bus_pkg.sv
src/axi_slave.sv
src/sys_bus_decoder.sv
src/reg_bank.sv
src/wait_state_ram.sv
src/axi_sys_top.sv
tests/tb_axi_sys_top.sv
+incdir+tests

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
  --top-module tb_axi_sys_top -f sim.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_axi_sys_top >> sim.log 2>&1 \
  || echo "Testbench failed" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
